//--- hdl/bus_decoder.sv
`timescale 1ns/1ps

module bus_decoder (
    input  logic                   clk,
    input  logic                   rst_n,
    // fetch side
    input  logic                   fetch_req,
    input  soc_map_pkg::bus_addr_t pc,
    output logic [31:0]            instr,
    output logic                   fetch_ready,
    // data side
    input  logic                   ren,
    input  logic                   wen,
    input  soc_map_pkg::bus_addr_t data_addr,
    input  logic [31:0]            wdata,
    input  logic [3:0]             be,
    output logic [31:0]            rdata,
    output logic                   data_ready,
    // on-chip RAM
    output logic                   fast_sel,
    output logic                   fast_wen,
    output soc_map_pkg::bus_addr_t fast_addr,
    output logic [31:0]            fast_wdata,
    output logic [3:0]             fast_be,
    input  logic [31:0]            fast_rdata,
    input  logic [31:0]            fast_instr,
    // timer block
    output logic                   timer_sel,
    output soc_map_pkg::bus_addr_t timer_addr,
    input  logic [31:0]            timer_rdata,
    // slow memory requests toward the arbiter
    mem_port_if.master             fetch_slow,
    mem_port_if.master             data_slow
);
    import soc_map_pkg::*;

    region_e     fetch_region;
    region_e     data_region;
    logic        data_access;
    logic [31:0] rd_word;
    logic [31:0] rdata_q;

    assign fetch_region = addr_region(pc);
    assign data_region  = addr_region(data_addr);
    assign data_access  = ren | wen;

    // fetch port never writes
    assign fetch_slow.req   = fetch_req && (fetch_region == region_slow);
    assign fetch_slow.wen   = 1'b0;
    assign fetch_slow.addr  = pc;
    assign fetch_slow.wdata = '0;
    assign fetch_slow.be    = '0;

    always_comb begin
        instr       = '0;
        fetch_ready = fetch_req;
        case (fetch_region)
            region_fast: instr = fast_instr;
            region_slow: begin
                instr       = fetch_slow.rdata;
                fetch_ready = fetch_req && fetch_slow.ready;
            end
            default: instr = '0;
        endcase
    end

    // strobes reach only the selected target
    assign fast_sel   = data_access && (data_region == region_fast);
    assign fast_wen   = wen && (data_region == region_fast);
    assign fast_addr  = data_addr;
    assign fast_wdata = wdata;
    assign fast_be    = be;

    assign timer_sel  = data_access && (data_region == region_timer);
    assign timer_addr = data_addr;

    assign data_slow.req   = data_access && (data_region == region_slow);
    assign data_slow.wen   = wen;
    assign data_slow.addr  = data_addr;
    assign data_slow.wdata = wdata;
    assign data_slow.be    = be;

    // unmapped reads give zero, unmapped writes go nowhere
    always_comb begin
        rd_word    = '0;
        data_ready = data_access;
        case (data_region)
            region_fast: rd_word = fast_rdata;
            region_slow: begin
                rd_word    = data_slow.rdata;
                data_ready = data_slow.ready;
            end
            region_timer: rd_word = timer_sel ? timer_rdata : '0;
            default: rd_word = '0;
        endcase
    end

    // last completed read, shown while the port waits
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rdata_q <= '0;
        end else if (ren && data_ready) begin
            rdata_q <= rd_word;
        end
    end

    assign rdata = (ren && data_ready) ? rd_word : rdata_q;

endmodule

//--- hdl/fast_ram.sv
`timescale 1ns/1ps

module fast_ram (
    input  logic                   clk,
    // data port
    input  logic                   sel,
    input  logic                   wen,
    input  soc_map_pkg::bus_addr_t addr,
    input  logic [31:0]            wdata,
    input  logic [3:0]             be,
    output logic [31:0]            rdata,
    // fetch port, read only
    input  soc_map_pkg::bus_addr_t fetch_addr,
    output logic [31:0]            instr
);
    import soc_map_pkg::*;

    logic [31:0]                   mem [fast_words];
    logic [$clog2(fast_words)-1:0] idx;
    logic [$clog2(fast_words)-1:0] fetch_idx;

    // word index from the byte offset
    assign idx       = addr.fields.offset[$clog2(fast_words)+1:2];
    assign fetch_idx = fetch_addr.fields.offset[$clog2(fast_words)+1:2];

    always_ff @(posedge clk) begin
        if (sel && wen) begin
            for (int b = 0; b < 4; b++) begin
                if (be[b]) begin
                    mem[idx][8*b +: 8] <= wdata[8*b +: 8];
                end
            end
        end
    end

    // both reads are combinational
    assign rdata = mem[idx];
    assign instr = mem[fetch_idx];

endmodule

//--- hdl/mem_port_if.sv
`timescale 1ns/1ps

interface mem_port_if;
    import soc_map_pkg::*;

    logic        req;
    logic        wen;
    bus_addr_t   addr;
    logic [31:0] wdata;
    logic [3:0]  be;
    logic [31:0] rdata;
    logic        ready;

    // fields held while req is high and ready is low
    modport master (output req, wen, addr, wdata, be, input rdata, ready);
    modport slave  (input req, wen, addr, wdata, be, output rdata, ready);

endinterface

//--- hdl/slow_mem.sv
`timescale 1ns/1ps

module slow_mem (
    input  logic     clk,
    input  logic     rst_n,
    mem_port_if.slave mem_slow
);
    import soc_map_pkg::*;

    logic [31:0]              mem [slow_words];
    logic [slow_cnt_bits-1:0] cnt;
    logic                     busy;
    logic                     start;
    logic                     finish;
    logic [$clog2(slow_words)-1:0] idx;

    assign idx = mem_slow.addr.fields.offset[$clog2(slow_words)+1:2];

    // no new access in the cycle that completes the previous one
    assign start  = mem_slow.req && !busy && !mem_slow.ready;
    assign finish = busy && (cnt == 1);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy           <= 1'b0;
            cnt            <= '0;
            mem_slow.ready <= 1'b0;
        end else begin
            mem_slow.ready <= finish;
            if (start) begin
                busy <= 1'b1;
                cnt  <= slow_cnt_bits'(slow_latency - 1);
            end else if (busy) begin
                cnt <= cnt - 1'b1;
                if (finish) begin
                    busy <= 1'b0;
                end
            end
        end
    end

    // access done at the edge that raises ready
    always_ff @(posedge clk) begin
        if (finish) begin
            if (mem_slow.wen) begin
                for (int b = 0; b < 4; b++) begin
                    if (mem_slow.be[b]) begin
                        mem[idx][8*b +: 8] <= mem_slow.wdata[8*b +: 8];
                    end
                end
            end else begin
                mem_slow.rdata <= mem[idx];
            end
        end
    end

endmodule

//--- hdl/slow_mem_arbiter.sv
`timescale 1ns/1ps

module slow_mem_arbiter (
    input  logic      clk,
    input  logic      rst_n,
    mem_port_if.slave  fetch_slow,
    mem_port_if.slave  data_slow,
    mem_port_if.master mem_slow
);
    import soc_map_pkg::*;

    logic data_want;
    logic fetch_want;
    logic busy_q;
    logic owner_fetch_q;
    logic pick_fetch;

    // only slow window addresses are passed on
    assign data_want  = data_slow.req && (addr_region(data_slow.addr) == region_slow);
    assign fetch_want = fetch_slow.req && (addr_region(fetch_slow.addr) == region_slow);

    // data port wins a tie when idle
    assign pick_fetch = busy_q ? owner_fetch_q : !data_want;

    always_comb begin
        if (pick_fetch) begin
            mem_slow.req   = fetch_want;
            mem_slow.wen   = fetch_slow.wen;
            mem_slow.addr  = fetch_slow.addr;
            mem_slow.wdata = fetch_slow.wdata;
            mem_slow.be    = fetch_slow.be;
        end else begin
            mem_slow.req   = data_want;
            mem_slow.wen   = data_slow.wen;
            mem_slow.addr  = data_slow.addr;
            mem_slow.wdata = data_slow.wdata;
            mem_slow.be    = data_slow.be;
        end
    end

    assign fetch_slow.rdata = mem_slow.rdata;
    assign data_slow.rdata  = mem_slow.rdata;
    assign fetch_slow.ready = mem_slow.ready && pick_fetch;
    assign data_slow.ready  = mem_slow.ready && !pick_fetch;

    // grant held until the owner's access completes
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_q        <= 1'b0;
            owner_fetch_q <= 1'b0;
        end else if (!busy_q) begin
            if (data_want || fetch_want) begin
                busy_q        <= 1'b1;
                owner_fetch_q <= !data_want;
            end
        end else if (mem_slow.req && mem_slow.ready) begin
            busy_q <= 1'b0;
        end
    end

endmodule

//--- hdl/soc_bus_top.sv
`timescale 1ns/1ps

module soc_bus_top (
    input  logic        clk,
    input  logic        rst_n,
    // fetch side
    input  logic [31:0] pc,
    input  logic        fetch_req,
    output logic [31:0] instr,
    output logic        fetch_ready,
    // data side
    input  logic [31:0] data_addr,
    input  logic        ren,
    input  logic        wen,
    input  logic [31:0] wdata,
    input  logic [3:0]  be,
    output logic [31:0] rdata,
    output logic        data_ready,
    input  logic        btn
);
    import soc_map_pkg::*;

    bus_addr_t   fast_addr;
    bus_addr_t   timer_addr;
    logic        fast_sel;
    logic        fast_wen;
    logic [31:0] fast_wdata;
    logic [3:0]  fast_be;
    logic [31:0] fast_rdata;
    logic [31:0] fast_instr;
    logic [31:0] timer_rdata;

    mem_port_if fetch_slow ();
    mem_port_if data_slow ();
    mem_port_if mem_slow ();

    bus_decoder bus_decoder_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .fetch_req   (fetch_req),
        .pc          (pc),
        .instr       (instr),
        .fetch_ready (fetch_ready),
        .ren         (ren),
        .wen         (wen),
        .data_addr   (data_addr),
        .wdata       (wdata),
        .be          (be),
        .rdata       (rdata),
        .data_ready  (data_ready),
        .fast_sel    (fast_sel),
        .fast_wen    (fast_wen),
        .fast_addr   (fast_addr),
        .fast_wdata  (fast_wdata),
        .fast_be     (fast_be),
        .fast_rdata  (fast_rdata),
        .fast_instr  (fast_instr),
        .timer_sel   (),
        .timer_addr  (timer_addr),
        .timer_rdata (timer_rdata),
        .fetch_slow  (fetch_slow.master),
        .data_slow   (data_slow.master)
    );

    slow_mem_arbiter slow_mem_arbiter_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .fetch_slow (fetch_slow.slave),
        .data_slow  (data_slow.slave),
        .mem_slow   (mem_slow.master)
    );

    slow_mem slow_mem_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .mem_slow (mem_slow.slave)
    );

    // fetch reads the RAM straight from pc
    fast_ram fast_ram_inst (
        .clk        (clk),
        .sel        (fast_sel),
        .wen        (fast_wen),
        .addr       (fast_addr),
        .wdata      (fast_wdata),
        .be         (fast_be),
        .rdata      (fast_rdata),
        .fetch_addr (pc),
        .instr      (fast_instr)
    );

    timer_regs timer_regs_inst (
        .clk   (clk),
        .rst_n (rst_n),
        .addr  (timer_addr),
        .rdata (timer_rdata),
        .btn   (btn)
    );

endmodule

//--- hdl/soc_map_pkg.sv
package soc_map_pkg;

    // on-chip RAM, single-cycle
    localparam logic [31:0] fast_base  = 32'h0000_0000;
    localparam int          fast_words = 1024;

    // external memory behind the arbiter
    localparam logic [31:0] slow_base  = 32'h8000_0000;
    localparam int          slow_words = 4096;

    // counter at offset 0, button at offset 4
    localparam logic [31:0] timer_base = 32'h1000_0000;
    localparam int          timer_bytes = 8;

    // cycles from an accepted slow access to its ready, at least 2
    localparam int slow_latency  = 3;
    localparam int slow_cnt_bits = $clog2(slow_latency + 1);

    typedef union packed {
        logic [31:0] raw;
        struct packed {
            logic [7:0]  region;
            logic [23:0] offset;
        } fields;
    } bus_addr_t;

    typedef enum logic [1:0] {
        region_fast,
        region_slow,
        region_timer,
        region_none
    } region_e;

    // region by top byte, offset checked against the block size
    function automatic region_e addr_region(bus_addr_t a);
        region_e r;
        r = region_none;
        if (a.fields.region == fast_base[31:24] && a.fields.offset < fast_words * 4) begin
            r = region_fast;
        end else if (a.fields.region == slow_base[31:24] &&
                     a.fields.offset < slow_words * 4) begin
            r = region_slow;
        end else if (a.fields.region == timer_base[31:24] && a.fields.offset < timer_bytes) begin
            r = region_timer;
        end
        return r;
    endfunction

endpackage

//--- hdl/timer_regs.sv
`timescale 1ns/1ps

module timer_regs (
    input  logic                   clk,
    input  logic                   rst_n,
    input  soc_map_pkg::bus_addr_t addr,
    output logic [31:0]            rdata,
    input  logic                   btn
);
    logic [31:0] counter;
    logic        btn_meta;
    logic        btn_sync;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            counter  <= '0;
            btn_meta <= 1'b0;
            btn_sync <= 1'b0;
        end else begin
            counter  <= counter + 1'b1;
            // two-flop synchronizer for the raw button
            btn_meta <= btn;
            btn_sync <= btn_meta;
        end
    end

    // offset 4 is the button, anything else in the block the counter
    assign rdata = addr.fields.offset[2] ? {31'b0, btn_sync} : counter;

endmodule

//--- sources.f
hdl/soc_map_pkg.sv
hdl/mem_port_if.sv
hdl/fast_ram.sv
hdl/timer_regs.sv
hdl/slow_mem.sv
hdl/slow_mem_arbiter.sv
hdl/bus_decoder.sv
hdl/soc_bus_top.sv
tests/tb_soc_bus.sv

//--- tests/tb_soc_bus.sv
`timescale 1ns/1ps

module tb_soc_bus;
    import soc_map_pkg::*;

    localparam int n_init     = 32;
    localparam int n_fast     = 40;
    localparam int n_slow     = 40;
    localparam int n_cont_dat = 24;
    localparam int n_cont_fch = 16;
    localparam int n_hole     = 8;
    localparam int n_recheck  = 32;
    localparam int n_timer    = 16;
    localparam int n_ops      = n_init + n_fast + n_slow + n_cont_dat + n_cont_fch +
                                2 * n_hole + n_recheck + n_timer;
    localparam int limit_cycles = n_ops * (2 * slow_latency + 4) + 10;

    logic        clk = 1'b0;
    logic        rst_n;
    logic [31:0] pc;
    logic        fetch_req;
    logic [31:0] instr;
    logic        fetch_ready;
    logic [31:0] data_addr;
    logic        ren;
    logic        wen;
    logic [31:0] wdata;
    logic [3:0]  be;
    logic [31:0] rdata;
    logic        data_ready;
    logic        btn;

    logic [31:0] fast_shadow [fast_words];
    logic [31:0] slow_shadow [slow_words];
    logic [31:0] rng_state = 32'h668d_1302;
    logic [31:0] last_read = '0;
    string       test_name = "reset";
    int          mismatches = 0;
    int          other_errors = 0;

    soc_bus_top soc_bus_top_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .pc          (pc),
        .fetch_req   (fetch_req),
        .instr       (instr),
        .fetch_ready (fetch_ready),
        .data_addr   (data_addr),
        .ren         (ren),
        .wen         (wen),
        .wdata       (wdata),
        .be          (be),
        .rdata       (rdata),
        .data_ready  (data_ready),
        .btn         (btn)
    );

    always #4 clk = ~clk;

    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // region from the memory map, top byte and block size
    function automatic region_e region_of(input logic [31:0] a);
        if (a[31:24] == fast_base[31:24] && a[23:0] < fast_words * 4) return region_fast;
        if (a[31:24] == slow_base[31:24] && a[23:0] < slow_words * 4) return region_slow;
        if (a[31:24] == timer_base[31:24] && a[23:0] < 8) return region_timer;
        return region_none;
    endfunction

    function automatic logic [31:0] expected_read(input logic [31:0] a);
        case (region_of(a))
            region_fast: return fast_shadow[a[11:2]];
            region_slow: return slow_shadow[a[13:2]];
            default:     return 32'h0;
        endcase
    endfunction

    // sixteen spread-out words per memory
    function automatic logic [31:0] slot_addr(input bit in_slow, input int i);
        if (in_slow) return slow_base + ((i * 251) % slow_words) * 4;
        return fast_base + ((i * 67) % fast_words) * 4;
    endfunction

    task automatic apply_write(input logic [31:0] a, input logic [31:0] d, input logic [3:0] m);
        for (int b = 0; b < 4; b++) begin
            if (m[b] && region_of(a) == region_fast) begin
                fast_shadow[a[11:2]][8*b +: 8] = d[8*b +: 8];
            end
            if (m[b] && region_of(a) == region_slow) begin
                slow_shadow[a[13:2]][8*b +: 8] = d[8*b +: 8];
            end
        end
    endtask

    task automatic report_mismatch(input logic [31:0] exp, input logic [31:0] act);
        mismatches++;
        $display("MISMATCH %s: expected %08h actual %08h", test_name, exp, act);
    endtask

    task automatic report_error(input string msg);
        other_errors++;
        $display("ERROR %s: %s", test_name, msg);
    endtask

    task automatic data_access(input logic is_write, input logic [31:0] a, input logic [31:0] d,
                               input logic [3:0] m, output logic [31:0] value);
        int waited;
        waited = 0;
        ren = !is_write;
        wen = is_write;
        data_addr = a;
        wdata = d;
        be = m;
        @(negedge clk);
        while (!data_ready) begin
            waited++;
            @(negedge clk);
        end
        value = rdata;
        if (region_of(a) == region_slow && waited < slow_latency) begin
            report_error("data_ready rose before the slow memory latency passed");
        end
        if (region_of(a) != region_slow && waited != 0) begin
            report_error("data_ready was not high in the cycle of the request");
        end
        @(posedge clk);
        #1;
        if (is_write) apply_write(a, d, m);
        ren = 1'b0;
        wen = 1'b0;
    endtask

    task automatic fetch_word(input logic [31:0] a);
        int waited;
        waited = 0;
        pc = a;
        fetch_req = 1'b1;
        @(negedge clk);
        while (!fetch_ready) begin
            waited++;
            @(negedge clk);
        end
        if (region_of(a) == region_slow && waited < slow_latency) begin
            report_error("fetch_ready rose before the slow memory latency passed");
        end
        if (region_of(a) != region_slow && waited != 0) begin
            report_error("fetch_ready was not high in the cycle of the request");
        end
        @(posedge clk);
        #1;
        fetch_req = 1'b0;
    endtask

    task automatic random_ops(input bit in_slow, input int count);
        logic [31:0] r;
        logic [31:0] v;
        for (int i = 0; i < count; i++) begin
            r = next_rand();
            if (r[4]) data_access(1'b1, slot_addr(in_slow, r[3:0]), next_rand(), r[8:5], v);
            else data_access(1'b0, slot_addr(in_slow, r[3:0]), 32'h0, 4'h0, v);
        end
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    // data reads against the shadow, rdata hold while waiting, fetch words
    always @(negedge clk) begin
        if (rst_n === 1'b1) begin
            if (ren && data_ready) begin
                if (region_of(data_addr) != region_timer &&
                    rdata !== expected_read(data_addr)) begin
                    report_mismatch(expected_read(data_addr), rdata);
                end
                last_read = rdata;
            end else if (rdata !== last_read) begin
                report_mismatch(last_read, rdata);
            end
            if (fetch_req && fetch_ready && instr !== expected_read(pc)) begin
                report_mismatch(expected_read(pc), instr);
            end
            if (!fetch_req && fetch_ready) begin
                report_error("fetch_ready was high with no fetch pending");
            end
            if (!ren && !wen && data_ready) begin
                report_error("data_ready was high with no data access pending");
            end
        end
    end

    initial begin : watchdog
        repeat (limit_cycles) @(posedge clk);
        $display("watchdog expired in %s because an access never completed", test_name);
        $display("errors: %0d mismatches, %0d other failures", mismatches, other_errors);
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin : main_seq
        logic [31:0] v;
        logic [31:0] c0;
        logic [31:0] r;
        rst_n = 1'b0;
        pc = '0;
        fetch_req = 1'b0;
        data_addr = '0;
        ren = 1'b0;
        wen = 1'b0;
        wdata = '0;
        be = '0;
        btn = 1'b0;
        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;

        test_name = "init";
        for (int i = 0; i < n_init; i++) begin
            data_access(1'b1, slot_addr(i >= 16, i % 16), next_rand(), 4'hf, v);
        end
        test_name = "fast_ram";
        random_ops(1'b0, n_fast);
        test_name = "slow_mem";
        random_ops(1'b1, n_slow);

        // fetch held in the slow region while the data port also uses it
        test_name = "contention";
        fork
            for (int i = 0; i < n_cont_fch; i++) begin
                fetch_word(slot_addr(!i[0], next_rand() % 16));
            end
            random_ops(1'b1, n_cont_dat);
        join

        test_name = "unmapped";
        for (int i = 0; i < n_hole; i++) begin
            r = next_rand();
            case (r % 3)
                0: data_addr = {8'h40, r[23:2], 2'b00};
                1: begin
                    c0 = slot_addr(1'b0, r[7:4]);
                    data_addr = {20'h00001, c0[11:2], 2'b00};
                end
                default: data_addr = 32'h1000_0100 + {r[7:2], 2'b00};
            endcase
            c0 = data_addr;
            data_access(1'b1, c0, next_rand(), 4'hf, v);
            data_access(1'b0, c0, 32'h0, 4'h0, v);
        end
        test_name = "recheck";
        for (int i = 0; i < n_recheck; i++) data_access(1'b0, slot_addr(i >= 16, i % 16), 0, 0, v);

        // the two counter reads are four cycles apart
        test_name = "timer";
        data_access(1'b0, timer_base, 32'h0, 4'h0, c0);
        idle_cycles(3);
        data_access(1'b0, timer_base, 32'h0, 4'h0, v);
        if (v !== c0 + 32'd4) report_mismatch(c0 + 32'd4, v);
        btn = 1'b1;
        idle_cycles(4);
        data_access(1'b0, timer_base + 4, 32'h0, 4'h0, v);
        if (v !== 32'd1) report_mismatch(32'd1, v);
        btn = 1'b0;
        idle_cycles(4);
        data_access(1'b0, timer_base + 4, 32'h0, 4'h0, v);
        if (v !== 32'd0) report_mismatch(32'd0, v);

        // slow read right after a fast read, rdata must hold meanwhile
        test_name = "hold";
        data_access(1'b0, slot_addr(1'b0, 1), 32'h0, 4'h0, v);
        data_access(1'b0, slot_addr(1'b1, 2), 32'h0, 4'h0, v);
        idle_cycles(2);

        $display("errors: %0d mismatches, %0d other failures", mismatches, other_errors);
        if (mismatches == 0 && other_errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule
